// ==== common/mmc5_pkg.sv ====
// MMC5 mapper package with bus widths, address pages and mode encodings
package mmc5_pkg;

	// Cartridge bus widths
	localparam int CPU_ADDR_W = 16;  // CPU address bus
	localparam int DATA_W     = 8;   // CPU data bus
	localparam int PRG_OUT_W  = 22;  // PRG memory address, ROM and RAM together
	localparam int BANK_W     = 8;   // PRG bank register, top bit is ROM select

	// Expansion RAM geometry
	localparam int EXRAM_AW    = 10;
	localparam int EXRAM_DEPTH = 1024;

	// First line the scanline compare can never match
	localparam logic [8:0] VISIBLE_LINES = 9'd240;

	// Value seen on reads that nothing drives
	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;

	// Upper PRG address bits of the save RAM window
	localparam logic [5:0] SAVE_RAM_PAGE = 6'b11_1100;

	// CPU address bits 15:10 of the two mapper pages
	localparam logic [5:0] REG_PAGE   = 6'b01_0100;  // $5000-$53FF
	localparam logic [5:0] EXRAM_PAGE = 6'b01_0111;  // $5C00-$5FFF

	// PRG window layout, $5100 bits 1:0
	typedef enum logic [1:0] {
		PRG_32K    = 2'd0,  // One 32K bank from prg_bank_3
		PRG_16K    = 2'd1,  // Two 16K banks
		PRG_16K_8K = 2'd2,  // 16K at $8000, 8K at $C000 and $E000
		PRG_8K     = 2'd3   // Four 8K banks
	} prg_mode_e;

	// ExRAM usage, $5104 bits 1:0
	typedef enum logic [1:0] {
		EXRAM_NT     = 2'd0,  // Extra nametable
		EXRAM_EXATTR = 2'd1,  // Extended attributes
		EXRAM_RAM    = 2'd2,  // Plain CPU RAM
		EXRAM_ROM    = 2'd3   // CPU RAM, write protected
	} exram_mode_e;

	// Register offsets inside the register page
	typedef enum logic [9:0] {
		REG_PRG_MODE   = 10'h100,
		REG_PROTECT_1  = 10'h102,
		REG_PROTECT_2  = 10'h103,
		REG_EXRAM_MODE = 10'h104,
		REG_RAM_BANK   = 10'h113,
		REG_PRG_BANK_0 = 10'h114,
		REG_PRG_BANK_1 = 10'h115,
		REG_PRG_BANK_2 = 10'h116,
		REG_PRG_BANK_3 = 10'h117,
		REG_IRQ_LINE   = 10'h203,
		REG_IRQ_STATUS = 10'h204,  // Write sets irq_enable, read returns status
		REG_MUL_LO     = 10'h205,
		REG_MUL_HI     = 10'h206
	} reg_addr_e;

endpackage

// ==== common/mapper_cfg_if.sv ====
// Mapper configuration bundle from the register file to the PRG mapper, IRQ unit and ExRAM
`timescale 1ns/1ns

interface mapper_cfg_if import mmc5_pkg::*; ();

	prg_mode_e         prg_mode;
	exram_mode_e       exram_mode;
	logic [2:0]        prg_ram_bank;   // Save RAM bank at $6000
	logic [BANK_W-1:0] prg_bank_0;
	logic [BANK_W-1:0] prg_bank_1;
	logic [BANK_W-1:0] prg_bank_2;
	logic [BANK_W-2:0] prg_bank_3;     // Always ROM, so no select bit
	logic              ram_write_ok;   // Both protect keys in place
	logic [7:0]        irq_line;
	logic              irq_enable;

	modport regs (output prg_mode, exram_mode, prg_ram_bank, prg_bank_0, prg_bank_1,
		prg_bank_2, prg_bank_3, ram_write_ok, irq_line, irq_enable);

	modport prg_map (input prg_mode, prg_ram_bank, prg_bank_0, prg_bank_1, prg_bank_2,
		prg_bank_3, ram_write_ok);

	modport irq (input irq_line, irq_enable);

	modport exram (input exram_mode);

endinterface

// ==== prg/prg_bank_map.sv ====
// PRG bank mapper, turns the CPU address into a ROM or RAM address and decides write access
`timescale 1ns/1ns

module prg_bank_map import mmc5_pkg::*; (
	input  logic [CPU_ADDR_W-1:0] prg_ain,
	input  logic                  prg_write,
	output logic [PRG_OUT_W-1:0]  prg_aout,
	output logic                  prg_allow,  // Cartridge memory may take this access
	mapper_cfg_if.prg_map         cfg
);

	logic [BANK_W-1:0] bank;      // Selected 8K bank, bit 7 set means ROM
	logic              rom_bank;
	logic              in_window; // $6000-$FFFF

	always_comb begin
		bank = {5'b0_0000, cfg.prg_ram_bank};  // $6000-$7FFF save RAM
		if (prg_ain[15]) begin
			case (cfg.prg_mode)
				PRG_32K:
					bank = {1'b1, cfg.prg_bank_3[6:2], prg_ain[14:13]};
				PRG_16K: begin
					if (prg_ain[14])
						bank = {1'b1, cfg.prg_bank_3[6:1], prg_ain[13]};  // $C000
					else
						bank = {cfg.prg_bank_1[7:1], prg_ain[13]};        // $8000
				end
				PRG_16K_8K: begin
					if (!prg_ain[14])
						bank = {cfg.prg_bank_1[7:1], prg_ain[13]};
					else if (!prg_ain[13])
						bank = cfg.prg_bank_2;                            // $C000 8K
					else
						bank = {1'b1, cfg.prg_bank_3};                    // $E000 8K
				end
				PRG_8K: begin
					case (prg_ain[14:13])
						2'd0:    bank = cfg.prg_bank_0;
						2'd1:    bank = cfg.prg_bank_1;
						2'd2:    bank = cfg.prg_bank_2;
						default: bank = {1'b1, cfg.prg_bank_3};
					endcase
				end
				default: bank = {1'b1, cfg.prg_bank_3};
			endcase
		end
	end

	assign rom_bank = bank[BANK_W-1];

	// ROM lands low, RAM banks go to the save RAM page
	assign prg_aout = rom_bank ? {2'b00, bank[BANK_W-2:0], prg_ain[12:0]}
	                           : {SAVE_RAM_PAGE, bank[2:0], prg_ain[12:0]};

	assign in_window = prg_ain[15] || (prg_ain[14] && prg_ain[13]);

	// Reads always pass, writes need a RAM bank and both keys
	assign prg_allow = in_window && (!prg_write || (!rom_bank && cfg.ram_write_ok));

endmodule

// ==== logic/scanline_irq.sv ====
// Scanline IRQ, flags the configured line and clears on a status read or frame end
`timescale 1ns/1ns

module scanline_irq import mmc5_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       ce,
	input  logic       ppu_ce,
	input  logic       ppu_in_frame,
	input  logic [8:0] ppu_scanline,
	input  logic       status_read,   // $5204 read acknowledge
	output logic       irq,
	output logic       irq_pending,   // Status bit 7
	mapper_cfg_if.irq  cfg
);

	logic last_line_bit;  // Scanline bit 0 from the previous tick
	logic line_step;      // Scanline changed since last tick
	logic line_match;

	assign line_step = (ppu_scanline[0] != last_line_bit);

	// Line 0 and lines past the visible area never fire
	assign line_match = (cfg.irq_line != 8'd0)
		&& ({1'b0, cfg.irq_line} < VISIBLE_LINES)
		&& (ppu_scanline == {1'b0, cfg.irq_line});

	always_ff @(posedge clk) begin
		if (reset) begin
			last_line_bit <= 1'b0;
			irq_pending   <= 1'b0;
		end else if (ce || ppu_ce) begin
			last_line_bit <= ppu_scanline[0];
			if (status_read || !ppu_in_frame)
				irq_pending <= 1'b0;  // Ack or vblank
			else if (line_step && line_match)
				irq_pending <= 1'b1;
		end
	end

	// Pending stays visible in status even while masked
	assign irq = irq_pending && cfg.irq_enable;

endmodule

// ==== logic/exram.sv ====
// Expansion RAM, 1K of CPU-visible memory at $5C00-$5FFF with mode-dependent access
`timescale 1ns/1ns

module exram import mmc5_pkg::*; (
	input  logic                  clk,
	input  logic                  ce,
	input  logic [CPU_ADDR_W-1:0] prg_ain,
	input  logic [DATA_W-1:0]     prg_din,
	input  logic                  prg_write,
	input  logic                  ppu_in_frame,
	output logic [DATA_W-1:0]     ram_rdata,   // One clk behind prg_ain
	output logic                  ram_hit,     // Page readable in current mode
	mapper_cfg_if.exram           cfg
);

	logic [DATA_W-1:0] mem [EXRAM_DEPTH];
	logic [EXRAM_AW-1:0] addr;
	logic page_sel;    // $5C00-$5FFF
	logic cpu_mode;    // RAM or ROM mode, CPU owns the array
	logic wr_en;

	assign addr     = prg_ain[EXRAM_AW-1:0];
	assign page_sel = (prg_ain[15:10] == EXRAM_PAGE);
	assign cpu_mode = (cfg.exram_mode == EXRAM_RAM) || (cfg.exram_mode == EXRAM_ROM);
	assign ram_hit  = page_sel && cpu_mode;

	// ROM mode drops writes
	assign wr_en = ce && prg_write && page_sel && (cfg.exram_mode != EXRAM_ROM);

	always_ff @(posedge clk) begin
		if (wr_en) begin
			// Nametable modes only take data while rendering, else store 0
			if (cfg.exram_mode == EXRAM_RAM || ppu_in_frame)
				mem[addr] <= prg_din;
			else
				mem[addr] <= '0;
		end
		ram_rdata <= mem[addr];  // Block RAM read port
	end

endmodule

// ==== logic/mmc5_regs.sv ====
// MMC5 register file, takes CPU writes at $5100-$5206, multiplies and muxes read data
`timescale 1ns/1ns

module mmc5_regs import mmc5_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,
	input  logic [CPU_ADDR_W-1:0] prg_ain,
	input  logic [DATA_W-1:0]     prg_din,
	input  logic                  prg_read,
	input  logic                  prg_write,
	input  logic                  ppu_in_frame,
	input  logic [DATA_W-1:0]     ram_rdata,    // Registered ExRAM byte
	input  logic                  ram_hit,
	input  logic                  irq_pending,
	output logic [DATA_W-1:0]     prg_dout,
	output logic                  status_read,  // One clk, clears irq_pending
	mapper_cfg_if.regs            cfg
);

	prg_mode_e         prg_mode;
	exram_mode_e       exram_mode;
	logic              protect_1;    // Key 1 holds %10
	logic              protect_2;    // Key 2 holds %01
	logic [2:0]        prg_ram_bank;
	logic [BANK_W-1:0] prg_bank_0;
	logic [BANK_W-1:0] prg_bank_1;
	logic [BANK_W-1:0] prg_bank_2;
	logic [BANK_W-2:0] prg_bank_3;
	logic [7:0]        irq_line;
	logic              irq_enable;
	logic [DATA_W-1:0] mul_a;
	logic [DATA_W-1:0] mul_b;
	logic [2*DATA_W-1:0] product;

	logic reg_page;  // Address falls in $5000-$53FF
	logic reg_wr;

	assign reg_page = (prg_ain[15:10] == REG_PAGE);
	assign reg_wr   = ce && prg_write && reg_page;

	always_ff @(posedge clk) begin
		if (reset) begin
			prg_mode     <= PRG_8K;         // Boot vector reachable from $E000
			exram_mode   <= EXRAM_NT;
			protect_1    <= 1'b0;
			protect_2    <= 1'b0;
			prg_ram_bank <= '0;
			prg_bank_0   <= '0;
			prg_bank_1   <= '0;
			prg_bank_2   <= '0;
			prg_bank_3   <= 7'h7F;          // Last ROM bank
			irq_line     <= '0;
			irq_enable   <= 1'b0;
			mul_a        <= '0;
			mul_b        <= '0;
		end else if (reg_wr) begin
			case (prg_ain[9:0])
				REG_PRG_MODE:   prg_mode <= prg_mode_e'(prg_din[1:0]);
				REG_PROTECT_1:  protect_1 <= (prg_din[1:0] == 2'b10);
				REG_PROTECT_2:  protect_2 <= (prg_din[1:0] == 2'b01);
				REG_EXRAM_MODE: exram_mode <= exram_mode_e'(prg_din[1:0]);
				REG_RAM_BANK:   prg_ram_bank <= prg_din[2:0];
				REG_PRG_BANK_0: prg_bank_0 <= prg_din;
				REG_PRG_BANK_1: prg_bank_1 <= prg_din;
				REG_PRG_BANK_2: prg_bank_2 <= prg_din;
				REG_PRG_BANK_3: prg_bank_3 <= prg_din[6:0];  // ROM select forced later
				REG_IRQ_LINE:   irq_line <= prg_din;
				REG_IRQ_STATUS: irq_enable <= prg_din[7];
				REG_MUL_LO:     mul_a <= prg_din;
				REG_MUL_HI:     mul_b <= prg_din;
				default: ;  // CHR, mirroring and split registers not kept
			endcase
		end
	end

	assign product = mul_a * mul_b;  // Unsigned 8x8

	// Configuration out to the consumers
	assign cfg.prg_mode     = prg_mode;
	assign cfg.exram_mode   = exram_mode;
	assign cfg.prg_ram_bank = prg_ram_bank;
	assign cfg.prg_bank_0   = prg_bank_0;
	assign cfg.prg_bank_1   = prg_bank_1;
	assign cfg.prg_bank_2   = prg_bank_2;
	assign cfg.prg_bank_3   = prg_bank_3;
	assign cfg.ram_write_ok = protect_1 && protect_2;
	assign cfg.irq_line     = irq_line;
	assign cfg.irq_enable   = irq_enable;

	// Only decode of $5204 for reads
	assign status_read = ce && prg_read && reg_page && (prg_ain[9:0] == REG_IRQ_STATUS);

	// CPU read mux
	always_comb begin
		prg_dout = OPEN_BUS;
		if (ram_hit)
			prg_dout = ram_rdata;
		else if (reg_page) begin
			case (prg_ain[9:0])
				REG_IRQ_STATUS: prg_dout = {irq_pending, ppu_in_frame, 6'b11_1111};
				REG_MUL_LO:     prg_dout = product[DATA_W-1:0];
				REG_MUL_HI:     prg_dout = product[2*DATA_W-1:DATA_W];
				default:        prg_dout = OPEN_BUS;
			endcase
		end
	end

endmodule

// ==== logic/mmc5_top.sv ====
// MMC5 mapper CPU side, joins register file, PRG banking, scanline IRQ and ExRAM
`timescale 1ns/1ns

module mmc5_top import mmc5_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,            // M2 qualifier for CPU cycles
	input  logic                  ppu_ce,        // PPU dot qualifier
	input  logic                  ppu_in_frame,  // PPU is rendering
	input  logic [CPU_ADDR_W-1:0] prg_ain,
	input  logic [DATA_W-1:0]     prg_din,
	input  logic                  prg_read,
	input  logic                  prg_write,
	input  logic [8:0]            ppu_scanline,
	output logic [DATA_W-1:0]     prg_dout,
	output logic [PRG_OUT_W-1:0]  prg_aout,
	output logic                  prg_allow,
	output logic                  irq
);

	mapper_cfg_if cfg ();

	logic [DATA_W-1:0] ram_rdata;
	logic              ram_hit;      // ExRAM owns the read bus
	logic              irq_pending;
	logic              status_read;  // $5204 read strobe

	mmc5_regs u_regs (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.prg_ain      (prg_ain),
		.prg_din      (prg_din),
		.prg_read     (prg_read),
		.prg_write    (prg_write),
		.ppu_in_frame (ppu_in_frame),
		.ram_rdata    (ram_rdata),
		.ram_hit      (ram_hit),
		.irq_pending  (irq_pending),
		.prg_dout     (prg_dout),
		.status_read  (status_read),
		.cfg          (cfg.regs)
	);

	exram u_exram (
		.clk          (clk),
		.ce           (ce),
		.prg_ain      (prg_ain),
		.prg_din      (prg_din),
		.prg_write    (prg_write),
		.ppu_in_frame (ppu_in_frame),
		.ram_rdata    (ram_rdata),
		.ram_hit      (ram_hit),
		.cfg          (cfg.exram)
	);

	prg_bank_map u_prg_map (
		.prg_ain   (prg_ain),
		.prg_write (prg_write),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.cfg       (cfg.prg_map)
	);

	scanline_irq u_irq (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.ppu_ce       (ppu_ce),
		.ppu_in_frame (ppu_in_frame),
		.ppu_scanline (ppu_scanline),
		.status_read  (status_read),
		.irq          (irq),
		.irq_pending  (irq_pending),
		.cfg          (cfg.irq)
	);

endmodule

// ==== test/tb_mmc5.sv ====
// MMC5 testbench that checks PRG banking, save RAM, multiplier, ExRAM and scanline IRQ
`timescale 1ns/1ns

module tb_mmc5 import mmc5_pkg::*; ();

	localparam int CLK_PERIOD     = 40;
	localparam int PLANNED_CYCLES = 300;  // Reset plus every bus cycle and scanline step

	logic        clk;
	logic        reset;
	logic        ce;
	logic        ppu_ce;
	logic        ppu_in_frame;
	logic [15:0] prg_ain;
	logic [7:0]  prg_din;
	logic        prg_read;
	logic        prg_write;
	logic [8:0]  ppu_scanline;
	logic [7:0]  prg_dout;
	logic [21:0] prg_aout;
	logic        prg_allow;
	logic        irq;

	int          imm_errors = 0;
	int          conc_errors = 0;
	logic [31:0] rng_state = 32'ha2c8;
	logic [7:0]  seen_dout;   // Outputs captured mid-cycle
	logic [21:0] seen_aout;
	logic        seen_allow;
	logic [7:0]  exram_model [1024];  // Expected ExRAM contents
	logic [9:0]  ex_off [8];
	logic [7:0]  bank_reg [4];

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	mmc5_top UUT (
		.clk          (clk),
		.reset        (reset),
		.ce           (ce),
		.ppu_ce       (ppu_ce),
		.ppu_in_frame (ppu_in_frame),
		.prg_ain      (prg_ain),
		.prg_din      (prg_din),
		.prg_read     (prg_read),
		.prg_write    (prg_write),
		.ppu_scanline (ppu_scanline),
		.prg_dout     (prg_dout),
		.prg_aout     (prg_aout),
		.prg_allow    (prg_allow),
		.irq          (irq)
	);

	// Nothing below $6000 is cartridge memory
	low_window_locked: assert property (@(posedge clk) disable iff (reset)
		(prg_ain < 16'h6000) |-> !prg_allow)
		else begin
			conc_errors++;
			$display("Fail %0t: prg_allow high for address %h", $time, prg_ain);
		end

	irq_quiet_in_reset: assert property (@(posedge clk) reset |=> !irq)
		else begin
			conc_errors++;
			$display("Fail %0t: irq high after a reset cycle", $time);
		end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Expected PRG address from the bank selection rules
	function automatic logic [21:0] model_prg_aout(input logic [1:0] mode, input logic [7:0] b0,
		input logic [7:0] b1, input logic [7:0] b2, input logic [6:0] b3, input logic [15:0] a);
		logic [7:0] bank;
		case (mode)
			2'd0: bank = {1'b1, b3[6:2], a[14:13]};              // One 32K window
			2'd1: bank = a[14] ? {1'b1, b3[6:1], a[13]} : {b1[7:1], a[13]};
			2'd2: begin
				if (!a[14])
					bank = {b1[7:1], a[13]};
				else
					bank = a[13] ? {1'b1, b3} : b2;
			end
			default: begin
				case (a[14:13])
					2'd0:    bank = b0;
					2'd1:    bank = b1;
					2'd2:    bank = b2;
					default: bank = {1'b1, b3};               // Last slot always ROM
				endcase
			end
		endcase
		if (bank[7])
			model_prg_aout = {2'b00, bank[6:0], a[12:0]};
		else
			model_prg_aout = {SAVE_RAM_PAGE, bank[2:0], a[12:0]};  // RAM bank in ROM area
	endfunction

	task automatic expect_equal(input string what, input logic [31:0] got,
		input logic [31:0] want);
		assert (got === want)
			else begin
				imm_errors++;
				$display("Fail %0t: %s is %h, expected %h", $time, what, got, want);
			end
	endtask

	// One CPU cycle with ce high and outputs sampled late in the cycle
	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data, input logic wr);
		prg_ain = addr;
		prg_din = data;
		prg_write = wr;
		prg_read = !wr;
		ce = 1'b1;
		#25;
		seen_dout = prg_dout;
		seen_aout = prg_aout;
		seen_allow = prg_allow;
		@(posedge clk);
		#5;
		ce = 1'b0;
		prg_write = 1'b0;
		prg_read = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(addr, data, 1'b1);
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		bus_cycle(addr, 8'h00, 1'b0);
	endtask

	// Address held one clk before the read so the registered byte is out
	task automatic exram_read(input logic [9:0] off);
		prg_ain = 16'h5C00 | {6'd0, off};
		@(posedge clk);
		#5;
		cpu_read(16'h5C00 | {6'd0, off});
	endtask

	task automatic step_line(input logic [8:0] line);
		ppu_scanline = line;
		ppu_ce = 1'b1;
		@(posedge clk);
		#5;
		ppu_ce = 1'b0;
	endtask

	initial begin
		#(PLANNED_CYCLES * CLK_PERIOD * 4);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [15:0] addr;
		logic [15:0] prod;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [2:0]  ram_bank;
		reset = 1'b1;
		ce = 1'b0;
		ppu_ce = 1'b0;
		ppu_in_frame = 1'b0;
		prg_ain = 16'h0000;
		prg_din = 8'h00;
		prg_read = 1'b0;
		prg_write = 1'b0;
		ppu_scanline = 9'd0;
		repeat (16) @(posedge clk);
		#5;
		reset = 1'b0;

		// Boot state maps the last ROM bank at $E000
		cpu_read(16'hE123);
		expect_equal("boot prg_aout", 32'(seen_aout), 32'({2'b00, 7'h7F, 13'h0123}));
		expect_equal("boot irq", 32'(irq), 32'd0);

		for (int m = 0; m < 4; m++) begin
			cpu_write(16'h5100, {6'd0, m[1:0]});
			for (int i = 0; i < 4; i++) begin
				r = lcg_next();
				bank_reg[i] = r[23:16];
				cpu_write(16'h5114 + 16'(i), bank_reg[i]);
			end
			for (int n = 0; n < 8; n++) begin
				r = lcg_next();
				addr = {1'b1, r[22:8]};  // Anywhere in $8000-$FFFF
				cpu_read(addr);
				expect_equal("prg_aout", 32'(seen_aout), 32'(model_prg_aout(m[1:0],
					bank_reg[0], bank_reg[1], bank_reg[2], bank_reg[3][6:0], addr)));
				expect_equal("read prg_allow", 32'(seen_allow), 32'd1);
			end
		end

		// Save RAM unlock sequence
		r = lcg_next();
		ram_bank = r[18:16];
		cpu_write(16'h5113, {5'd0, ram_bank});
		cpu_write(16'h6000, 8'h5A);
		expect_equal("locked allow", 32'(seen_allow), 32'd0);
		cpu_write(16'h5102, 8'h02);
		cpu_write(16'h6000, 8'h5A);
		expect_equal("one key allow", 32'(seen_allow), 32'd0);
		cpu_write(16'h5103, 8'h01);
		cpu_write(16'h6000, 8'h5A);
		expect_equal("unlocked allow", 32'(seen_allow), 32'd1);
		expect_equal("save ram aout", 32'(seen_aout), 32'({SAVE_RAM_PAGE, ram_bank, 13'h0}));
		cpu_write(16'h5102, 8'h03);  // Wrong key locks again
		cpu_write(16'h6000, 8'h5A);
		expect_equal("relocked allow", 32'(seen_allow), 32'd0);

		for (int n = 0; n < 8; n++) begin
			r = lcg_next();
			a = r[23:16];
			b = r[31:24];
			prod = {8'd0, a} * {8'd0, b};
			cpu_write(16'h5205, a);
			cpu_write(16'h5206, b);
			cpu_read(16'h5205);
			expect_equal("product low", 32'(seen_dout), 32'(prod[7:0]));
			cpu_read(16'h5206);
			expect_equal("product high", 32'(seen_dout), 32'(prod[15:8]));
		end

		cpu_write(16'h5104, 8'h02);  // RAM mode
		for (int n = 0; n < 8; n++) begin
			r = lcg_next();
			ex_off[n] = r[25:16];
			exram_model[ex_off[n]] = r[7:0];
			cpu_write(16'h5C00 | {6'd0, ex_off[n]}, r[7:0]);
		end
		for (int n = 0; n < 8; n++) begin
			exram_read(ex_off[n]);
			expect_equal("exram ram mode", 32'(seen_dout), 32'(exram_model[ex_off[n]]));
		end
		cpu_write(16'h5104, 8'h03);  // ROM mode drops writes
		for (int n = 0; n < 8; n++)
			cpu_write(16'h5C00 | {6'd0, ex_off[n]}, ~exram_model[ex_off[n]]);
		for (int n = 0; n < 8; n++) begin
			exram_read(ex_off[n]);
			expect_equal("exram rom mode", 32'(seen_dout), 32'(exram_model[ex_off[n]]));
		end
		cpu_write(16'h5104, 8'h00);
		for (int n = 0; n < 4; n++) begin
			exram_read(ex_off[n]);
			expect_equal("exram mode 0", 32'(seen_dout), 32'(OPEN_BUS));
		end

		// Scanline IRQ on line 20
		ppu_in_frame = 1'b1;
		cpu_write(16'h5203, 8'd20);
		cpu_write(16'h5204, 8'h80);
		for (int n = 1; n <= 22; n++) begin
			step_line(9'(n));
			expect_equal("irq on line step", 32'(irq), 32'(n >= 20));
		end
		cpu_read(16'h5204);
		expect_equal("status bits", 32'(seen_dout[7:6]), 32'd3);
		expect_equal("irq after status", 32'(irq), 32'd0);
		cpu_write(16'h5203, 8'd0);  // Line 0 is never compared
		for (int n = 31; n >= 0; n--) begin  // Counting down so line 0 comes after a line change
			step_line(9'(n));
			expect_equal("irq with line 0", 32'(irq), 32'd0);
		end

		$display("Checks finished, %0d immediate and %0d concurrent assertion errors",
			imm_errors, conc_errors);
		if (imm_errors == 0 && conc_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
common/mmc5_pkg.sv
common/mapper_cfg_if.sv
prg/prg_bank_map.sv
logic/scanline_irq.sv
logic/exram.sv
logic/mmc5_regs.sv
logic/mmc5_top.sv
test/tb_mmc5.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the MMC5 testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
rm -f "$LOG"

verilator --binary --assert --top-module tb_mmc5 -f vlog.f -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -qx "Test OK" "$LOG"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG"
	exit 1
fi
